//--- compile.f
source/cache_nb_pkg.sv
source/data_mem_if.sv
source/mem_1rw_byte_mask.sv
source/store_align.sv
source/load_extract.sv
source/cache_data_mem.sv
source/cache_data_top.sv
verification/data_mem_checker.sv
verification/tb_cache_data_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cache data memory testbench with Verilator and runs it.
# The run counts as passed only when the log holds the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_cache_data_top -Mdir obj_dir -f compile.f

./obj_dir/Vtb_cache_data_top | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- source/cache_data_mem.sv
// ----------------------------------------------------------------------
// Cache data memory block
//   RAM address from way id and set/word address
//   store alignment, byte-masked RAM, load extraction
//   load control capture for the pending read result
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cache_data_mem #(
  parameter int data_width_p          = 32,
  parameter int ways_p                = 4,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  data_mem_if.mem                 req,
  output logic [data_width_p-1:0] data_o
);
  import cache_nb_pkg::*;

  localparam int lanes_lp      = byte_lanes(data_width_p);
  localparam int sel_width_lp  = byte_sel_width(data_width_p);
  localparam int addr_width_lp = addr_width(ways_p, sets_p, block_size_in_words_p);
  localparam int els_lp        = ways_p * sets_p * block_size_in_words_p;

  logic [addr_width_lp-1:0] ram_addr;
  logic [data_width_p-1:0]  ram_wdata;
  logic [lanes_lp-1:0]      ram_mask;
  logic [data_width_p-1:0]  ram_rdata;
  logic                     load_en;
  logic                     sigext_op_r;
  size_op_e                 size_op_r;
  logic [sel_width_lp-1:0]  byte_sel_r;

  assign ram_addr = {req.way_id, req.addr};  // Way in the upper bits
  assign load_en  = req.v & ~req.write_not_read;

  store_align #(.data_width_p(data_width_p)) u_store_align (
    .size_op_i  (req.size_op),
    .byte_sel_i (req.byte_sel),
    .mask_op_i  (req.mask_op),
    .mask_i     (req.mask),
    .data_i     (req.data),
    .data_o     (ram_wdata),
    .mask_o     (ram_mask)
  );

  mem_1rw_byte_mask #(.data_width_p(data_width_p), .els_p(els_lp)) u_ram (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .v_i          (req.v),
    .w_i          (req.write_not_read),
    .addr_i       (ram_addr),
    .data_i       (ram_wdata),
    .write_mask_i (ram_mask),
    .data_o       (ram_rdata)
  );

  // Writes leave the pending load's controls alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sigext_op_r <= 1'b0;
      size_op_r   <= SIZE_BYTE;
      byte_sel_r  <= '0;
    end else if (load_en) begin
      sigext_op_r <= req.sigext_op;
      size_op_r   <= req.size_op;
      byte_sel_r  <= req.byte_sel;
    end
  end

  load_extract #(.data_width_p(data_width_p)) u_load_extract (
    .size_op_i   (size_op_r),
    .sigext_op_i (sigext_op_r),
    .byte_sel_i  (byte_sel_r),
    .data_i      (ram_rdata),
    .data_o      (data_o)
  );

endmodule

//--- source/cache_data_top.sv
// ----------------------------------------------------------------------
// Top level of the cache data memory subsystem
//   plain request ports copied onto the request bundle
//   data memory block instance
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module cache_data_top #(
  parameter int data_width_p          = 32,
  parameter int ways_p                = 4,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic                                                 v_i,
  input  logic                                                 write_not_read_i,
  input  logic [cache_nb_pkg::way_width(ways_p)-1:0]           way_id_i,
  input  logic [cache_nb_pkg::set_word_width(sets_p, block_size_in_words_p)-1:0] addr_i,
  input  cache_nb_pkg::size_op_e                               size_op_i,
  input  logic                                                 sigext_op_i,
  input  logic                                                 mask_op_i,
  input  logic [cache_nb_pkg::byte_lanes(data_width_p)-1:0]    mask_i,
  input  logic [cache_nb_pkg::byte_sel_width(data_width_p)-1:0] byte_sel_i,
  input  logic [data_width_p-1:0]                              data_i,
  output logic [data_width_p-1:0]                              data_o
);

  data_mem_if #(
    .data_width_p          (data_width_p),
    .ways_p                (ways_p),
    .sets_p                (sets_p),
    .block_size_in_words_p (block_size_in_words_p)
  ) req_if ();

  // Requester side of the bundle
  assign req_if.v              = v_i;
  assign req_if.write_not_read = write_not_read_i;
  assign req_if.way_id         = way_id_i;
  assign req_if.addr           = addr_i;
  assign req_if.size_op        = size_op_i;
  assign req_if.sigext_op      = sigext_op_i;
  assign req_if.mask_op        = mask_op_i;
  assign req_if.mask           = mask_i;
  assign req_if.byte_sel       = byte_sel_i;
  assign req_if.data           = data_i;

  cache_data_mem #(
    .data_width_p          (data_width_p),
    .ways_p                (ways_p),
    .sets_p                (sets_p),
    .block_size_in_words_p (block_size_in_words_p)
  ) u_data_mem (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req    (req_if.mem),
    .data_o (data_o)
  );

endmodule

//--- source/cache_nb_pkg.sv
// ----------------------------------------------------------------------
// Shared definitions for the non-blocking cache data memory
//   size_op_e      access size code for loads and stores
//   width helpers  byte lanes, byte select, way and RAM address widths
//   size helpers   number of sizes in use and clamped size index
// ----------------------------------------------------------------------
package cache_nb_pkg;

  // Access size, DWORD only meaningful on a 64-bit word
  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'd0,
    SIZE_HALF  = 2'd1,
    SIZE_WORD  = 2'd2,
    SIZE_DWORD = 2'd3
  } size_op_e;

  // Never narrower than one bit, so single-entry fields still exist
  function automatic int safe_clog2(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic int byte_lanes(int width);
    return width / 8;
  endfunction

  function automatic int byte_sel_width(int width);
    return safe_clog2(byte_lanes(width));
  endfunction

  function automatic int way_width(int ways);
    return safe_clog2(ways);
  endfunction

  // Set index plus word offset within the block
  function automatic int set_word_width(int sets, int block_words);
    return safe_clog2(sets) + safe_clog2(block_words);
  endfunction

  function automatic int addr_width(int ways, int sets, int block_words);
    return way_width(ways) + set_word_width(sets, block_words);
  endfunction

  // Sizes from byte up to the full word, at most four
  function automatic int size_count(int width);
    int n;
    n = byte_sel_width(width) + 1;
    return (n < 4) ? n : 4;
  endfunction

  // Codes above the word size fall back to the full word
  function automatic int size_index(size_op_e op, int width);
    int last;
    last = size_count(width) - 1;
    return (int'(op) > last) ? last : int'(op);
  endfunction

endpackage

//--- source/data_mem_if.sv
// ----------------------------------------------------------------------
// Request bundle for the cache data memory
//   requester modport drives the packet, mem modport receives it
// ----------------------------------------------------------------------
`timescale 1ns/100ps

interface data_mem_if #(
  parameter int data_width_p          = 32,
  parameter int ways_p                = 4,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
);
  import cache_nb_pkg::*;

  logic                                               v;
  logic                                               write_not_read;
  logic [way_width(ways_p)-1:0]                       way_id;
  logic [set_word_width(sets_p, block_size_in_words_p)-1:0] addr;
  size_op_e                                           size_op;
  logic                                               sigext_op;
  logic                                               mask_op;   // Use mask and data as given
  logic [byte_lanes(data_width_p)-1:0]                mask;
  logic [byte_sel_width(data_width_p)-1:0]            byte_sel;
  logic [data_width_p-1:0]                            data;

  modport requester (output v, write_not_read, way_id, addr, size_op,
                     sigext_op, mask_op, mask, byte_sel, data);

  modport mem (input v, write_not_read, way_id, addr, size_op,
               sigext_op, mask_op, mask, byte_sel, data);

endinterface

//--- source/load_extract.sv
// ----------------------------------------------------------------------
// Load extraction
//   selects the addressed byte, halfword or word of the read word
//   zero or sign extends it to the full word width
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module load_extract #(
  parameter int data_width_p = 32
) (
  input  cache_nb_pkg::size_op_e                              size_op_i,
  input  logic                                                sigext_op_i,
  input  logic [cache_nb_pkg::byte_sel_width(data_width_p)-1:0] byte_sel_i,
  input  logic [data_width_p-1:0]                             data_i,
  output logic [data_width_p-1:0]                             data_o
);
  import cache_nb_pkg::*;

  localparam int sizes_lp = size_count(data_width_p);

  logic [sizes_lp-1:0][data_width_p-1:0] size_data;
  int                                    size_idx;

  for (genvar i = 0; i < sizes_lp; i++) begin : g_size
    if (i == sizes_lp - 1) begin : g_full
      assign size_data[i] = data_i;  // Full word, nothing to extend
    end else begin : g_part
      localparam int chunk_w_lp = 8 * (2 ** i);

      logic [chunk_w_lp-1:0] chunk;
      logic                  fill;

      // Byte select bits above the alignment pick the chunk
      assign chunk = data_i[(byte_sel_i >> i) * chunk_w_lp +: chunk_w_lp];
      assign fill  = sigext_op_i & chunk[chunk_w_lp-1];

      assign size_data[i] = {{(data_width_p - chunk_w_lp){fill}}, chunk};
    end
  end

  assign size_idx = size_index(size_op_i, data_width_p);
  assign data_o   = size_data[size_idx];

endmodule

//--- source/mem_1rw_byte_mask.sv
// ----------------------------------------------------------------------
// Single-port synchronous RAM
//   per-byte write enable on writes
//   registered read output, held until the next read
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module mem_1rw_byte_mask #(
  parameter int data_width_p = 32,
  parameter int els_p        = 256
) (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          v_i,
  input  logic                                          w_i,
  input  logic [cache_nb_pkg::safe_clog2(els_p)-1:0]    addr_i,
  input  logic [data_width_p-1:0]                       data_i,
  input  logic [cache_nb_pkg::byte_lanes(data_width_p)-1:0] write_mask_i,
  output logic [data_width_p-1:0]                       data_o
);
  import cache_nb_pkg::*;

  localparam int lanes_lp = byte_lanes(data_width_p);

  logic [data_width_p-1:0] mem_r [els_p];
  logic [data_width_p-1:0] data_r;
  logic                    wr_en;
  logic                    rd_en;

  assign wr_en = v_i & w_i;
  assign rd_en = v_i & ~w_i;

  // Storage array
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int i = 0; i < lanes_lp; i++) begin
        if (write_mask_i[i]) begin
          mem_r[addr_i][8*i +: 8] <= data_i[8*i +: 8];
        end
      end
    end
  end

  // Read register only moves on a valid read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_r <= '0;
    end else if (rd_en) begin
      data_r <= mem_r[addr_i];
    end
  end

  assign data_o = data_r;

endmodule

//--- source/store_align.sv
// ----------------------------------------------------------------------
// Store alignment
//   replicates store data across the byte lanes of a word
//   decodes size and byte select into the byte write mask
//   explicit mask requests bypass both
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module store_align #(
  parameter int data_width_p = 32
) (
  input  cache_nb_pkg::size_op_e                              size_op_i,
  input  logic [cache_nb_pkg::byte_sel_width(data_width_p)-1:0] byte_sel_i,
  input  logic                                                mask_op_i,
  input  logic [cache_nb_pkg::byte_lanes(data_width_p)-1:0]   mask_i,
  input  logic [data_width_p-1:0]                             data_i,
  output logic [data_width_p-1:0]                             data_o,
  output logic [cache_nb_pkg::byte_lanes(data_width_p)-1:0]   mask_o
);
  import cache_nb_pkg::*;

  localparam int lanes_lp = byte_lanes(data_width_p);
  localparam int sizes_lp = size_count(data_width_p);

  logic [sizes_lp-1:0][data_width_p-1:0] size_data;
  logic [sizes_lp-1:0][lanes_lp-1:0]     size_mask;
  int                                    size_idx;

  for (genvar i = 0; i < sizes_lp; i++) begin : g_size
    localparam int chunk_w_lp = 8 * (2 ** i);

    // Low chunk copied into every slot of its size
    assign size_data[i] = {(data_width_p / chunk_w_lp){data_i[0 +: chunk_w_lp]}};

    if (i == sizes_lp - 1) begin : g_full
      assign size_mask[i] = '1;
    end else begin : g_part
      // Lane j belongs to the selected chunk when the bits above
      // the chunk alignment match the byte select
      for (genvar j = 0; j < lanes_lp; j++) begin : g_lane
        assign size_mask[i][j] = ((j >> i) == (byte_sel_i >> i));
      end
    end
  end

  assign size_idx = size_index(size_op_i, data_width_p);

  assign data_o = mask_op_i ? data_i : size_data[size_idx];
  assign mask_o = mask_op_i ? mask_i : size_mask[size_idx];

endmodule

//--- verification/data_mem_checker.sv
// ----------------------------------------------------------------------
// Checker for the cache data memory top level
//   byte-wise shadow memory updated by the store rules
//   expected load results by the extraction rules
//   per-test result lines, hold check and error counts
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module data_mem_checker #(
  parameter int data_width_p          = 32,
  parameter int ways_p                = 4,
  parameter int sets_p                = 16,
  parameter int block_size_in_words_p = 4
) (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic                                                  v_i,
  input  logic                                                  write_not_read_i,
  input  logic [cache_nb_pkg::way_width(ways_p)-1:0]            way_id_i,
  input  logic [cache_nb_pkg::set_word_width(sets_p, block_size_in_words_p)-1:0] addr_i,
  input  cache_nb_pkg::size_op_e                                size_op_i,
  input  logic                                                  sigext_op_i,
  input  logic                                                  mask_op_i,
  input  logic [cache_nb_pkg::byte_lanes(data_width_p)-1:0]     mask_i,
  input  logic [cache_nb_pkg::byte_sel_width(data_width_p)-1:0] byte_sel_i,
  input  logic [data_width_p-1:0]                               data_i,
  input  logic [data_width_p-1:0]                               dut_data_i,
  output int                                                    errors_o,
  output int                                                    tests_o
);
  import cache_nb_pkg::*;

  localparam int lanes_lp = byte_lanes(data_width_p);
  localparam int words_lp = ways_p * sets_p * block_size_in_words_p;

  logic [7:0]              shadow [words_lp * lanes_lp];
  logic [data_width_p-1:0] exp_data   = '0;  // Value data_o must show now
  string                   pend_name  = "";
  logic                    pend_check = 1'b0;
  string                   rep_name   = "";
  logic                    rep_now    = 1'b0;
  logic                    armed      = 1'b0;
  logic                    in_reset   = 1'b0;
  int                      err_count  = 0;
  int                      test_count = 0;

  assign errors_o = err_count;
  assign tests_o  = test_count;

  // Called by the testbench as it drives each table entry
  task automatic note_test(input string name, input logic check);
    pend_name  = name;
    pend_check = check;
  endtask

  // Way id sits above the set and word address
  function automatic int word_base();
    return (int'(way_id_i) * sets_p * block_size_in_words_p + int'(addr_i)) * lanes_lp;
  endfunction

  task automatic store_shadow();
    int base;
    int nb;
    int sel;
    base = word_base();
    nb   = 1 << int'(size_op_i);
    sel  = int'(byte_sel_i);
    for (int j = 0; j < lanes_lp; j++) begin
      if (mask_op_i) begin
        if (mask_i[j]) shadow[base + j] = data_i[8*j +: 8];
      end else if (nb >= lanes_lp || (j / nb) == (sel / nb)) begin
        shadow[base + j] = data_i[8*(j % nb) +: 8];  // Low bytes repeat in every slot
      end
    end
  endtask

  function automatic logic [data_width_p-1:0] load_expect();
    logic [data_width_p-1:0] word;
    logic [data_width_p-1:0] result;
    int                      base;
    int                      nb;
    int                      first;
    base = word_base();
    for (int j = 0; j < lanes_lp; j++) word[8*j +: 8] = shadow[base + j];
    nb = 1 << int'(size_op_i);
    if (nb >= lanes_lp) return word;
    first  = (int'(byte_sel_i) / nb) * nb;
    result = '0;
    for (int k = 0; k < nb; k++) result[8*k +: 8] = word[8*(first + k) +: 8];
    if (sigext_op_i && result[8*nb-1]) begin
      for (int k = nb; k < lanes_lp; k++) result[8*k +: 8] = 8'hff;
    end
    return result;
  endfunction

  task automatic report_result(input string name, input logic [data_width_p-1:0] expected);
    test_count++;
    if (dut_data_i === expected) begin
      $display("PASS %s", name);
    end else begin
      err_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, dut_data_i);
    end
  endtask

  // Inputs are stable at the rising edge
  always @(posedge clk_i) begin
    rep_now = 1'b0;
    if (rst_i) begin
      exp_data = '0;
      armed    = 1'b1;
      in_reset = 1'b1;
    end else if (v_i) begin
      rep_now  = pend_check;
      rep_name = pend_name;
      if (write_not_read_i) begin
        store_shadow();
      end else begin
        exp_data = load_expect();
      end
    end
  end

  // data_o settles well before the falling edge
  always @(negedge clk_i) begin
    if (armed && in_reset && !rst_i) begin
      in_reset = 1'b0;
      report_result("reset_zero", '0);
    end else if (armed && rep_now) begin
      report_result(rep_name, exp_data);
    end else if (armed && dut_data_i !== exp_data) begin
      err_count++;
      $display("data_o changed without a read: held %h, now %h", exp_data, dut_data_i);
    end
  end

endmodule

//--- verification/tb_cache_data_top.sv
// ----------------------------------------------------------------------
// Testbench for the cache data memory top level
//   clock, reset and cycle timeout
//   stimulus table applied one entry per cycle, idle cycle between
// ----------------------------------------------------------------------
`timescale 1ns/100ps

module tb_cache_data_top;
  import cache_nb_pkg::*;

  localparam int data_width_lp   = 32;
  localparam int ways_lp         = 4;
  localparam int sets_lp         = 16;
  localparam int block_words_lp  = 4;
  localparam int reset_cycles_lp = 8;
  localparam int max_steps_lp    = 64;
  localparam int way_w_lp        = way_width(ways_lp);
  localparam int addr_w_lp       = set_word_width(sets_lp, block_words_lp);
  localparam int lanes_lp        = byte_lanes(data_width_lp);
  localparam int sel_w_lp        = byte_sel_width(data_width_lp);

  logic                     clk;
  logic                     rst;
  logic                     v;
  logic                     wr;
  logic [way_w_lp-1:0]      way_id;
  logic [addr_w_lp-1:0]     addr;
  size_op_e                 size_op;
  logic                     sigext;
  logic                     mask_op;
  logic [lanes_lp-1:0]      mask;
  logic [sel_w_lp-1:0]      byte_sel;
  logic [data_width_lp-1:0] wdata;
  logic [data_width_lp-1:0] rdata;
  int                       errors;
  int                       tests;

  string                    tbl_name  [max_steps_lp];
  logic                     tbl_write [max_steps_lp];
  logic [way_w_lp-1:0]      tbl_way   [max_steps_lp];
  logic [addr_w_lp-1:0]     tbl_addr  [max_steps_lp];
  size_op_e                 tbl_size  [max_steps_lp];
  logic                     tbl_sext  [max_steps_lp];
  logic                     tbl_mop   [max_steps_lp];
  logic [lanes_lp-1:0]      tbl_mask  [max_steps_lp];
  logic [sel_w_lp-1:0]      tbl_sel   [max_steps_lp];
  logic [data_width_lp-1:0] tbl_data  [max_steps_lp];
  logic                     tbl_check [max_steps_lp];
  int                       n_steps       = 0;
  int                       seed          = 58;
  int                       cycle_count   = 0;
  int                       timeout_limit = 0;

  cache_data_top #(
    .data_width_p(data_width_lp), .ways_p(ways_lp),
    .sets_p(sets_lp), .block_size_in_words_p(block_words_lp)
  ) uut (
    .clk_i(clk), .rst_i(rst), .v_i(v), .write_not_read_i(wr), .way_id_i(way_id),
    .addr_i(addr), .size_op_i(size_op), .sigext_op_i(sigext), .mask_op_i(mask_op),
    .mask_i(mask), .byte_sel_i(byte_sel), .data_i(wdata), .data_o(rdata)
  );

  data_mem_checker #(
    .data_width_p(data_width_lp), .ways_p(ways_lp),
    .sets_p(sets_lp), .block_size_in_words_p(block_words_lp)
  ) chk (
    .clk_i(clk), .rst_i(rst), .v_i(v), .write_not_read_i(wr), .way_id_i(way_id),
    .addr_i(addr), .size_op_i(size_op), .sigext_op_i(sigext), .mask_op_i(mask_op),
    .mask_i(mask), .byte_sel_i(byte_sel), .data_i(wdata), .dut_data_i(rdata),
    .errors_o(errors), .tests_o(tests)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count++;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      $display("Run timed out after %0d cycles without finishing the table", cycle_count);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic add_step(input string name, input logic w, input logic [way_w_lp-1:0] wy,
                          input logic [addr_w_lp-1:0] a, input size_op_e sz, input logic sx,
                          input logic mop, input logic [lanes_lp-1:0] m,
                          input logic [sel_w_lp-1:0] sel, input logic [data_width_lp-1:0] d,
                          input logic check);
    tbl_name[n_steps]  = name;
    tbl_write[n_steps] = w;
    tbl_way[n_steps]   = wy;
    tbl_addr[n_steps]  = a;
    tbl_size[n_steps]  = sz;
    tbl_sext[n_steps]  = sx;
    tbl_mop[n_steps]   = mop;
    tbl_mask[n_steps]  = m;
    tbl_sel[n_steps]   = sel;
    tbl_data[n_steps]  = d;
    tbl_check[n_steps] = check;
    n_steps++;
  endtask

  // Columns: name, write, way, addr, size, sext, mask_op, mask, byte_sel, data, check
  task automatic build_table();
    for (int w = 0; w < ways_lp; w++) begin
      add_step($sformatf("wr_word_way%0d", w), 1, w, 5, SIZE_WORD, 0, 0, 0, 0, $random(seed), 0);
    end
    for (int w = 0; w < ways_lp; w++) begin
      add_step($sformatf("rd_word_way%0d", w), 0, w, 5, SIZE_WORD, 0, 0, 0, 0, 0, 1);
    end
    add_step("wr_byte_base", 1, 1, 9, SIZE_WORD, 0, 0, 0, 0, 32'h1122_3344, 0);
    for (int s = 0; s < lanes_lp; s++) begin
      add_step($sformatf("wr_byte_sel%0d", s), 1, 1, 9, SIZE_BYTE, 0, 0, 0, s,
               32'h5A5A_5AA0 + s, 0);
      add_step($sformatf("rd_after_byte%0d", s), 0, 1, 9, SIZE_WORD, 0, 0, 0, 0, 0, 1);
    end
    add_step("wr_half_base", 1, 2, 3, SIZE_WORD, 0, 0, 0, 0, $random(seed), 0);
    add_step("wr_half_lo", 1, 2, 3, SIZE_HALF, 0, 0, 0, 0, 32'hFFFF_BEEF, 0);
    add_step("wr_half_hi", 1, 2, 3, SIZE_HALF, 0, 0, 0, 2, 32'h0000_1234, 0);
    add_step("rd_half_lo", 0, 2, 3, SIZE_HALF, 0, 0, 0, 0, 0, 1);
    add_step("rd_half_hi", 0, 2, 3, SIZE_HALF, 0, 0, 0, 2, 0, 1);
    add_step("rd_half_odd_sel", 0, 2, 3, SIZE_HALF, 0, 0, 0, 3, 0, 1);
    add_step("rd_half_word", 0, 2, 3, SIZE_WORD, 0, 0, 0, 0, 0, 1);
    add_step("wr_sext_base", 1, 3, 12, SIZE_WORD, 0, 0, 0, 0, 32'h80F0_7F81, 0);
    add_step("rd_byte0_zext", 0, 3, 12, SIZE_BYTE, 0, 0, 0, 0, 0, 1);
    add_step("rd_byte0_sext", 0, 3, 12, SIZE_BYTE, 1, 0, 0, 0, 0, 1);
    add_step("rd_byte1_sext", 0, 3, 12, SIZE_BYTE, 1, 0, 0, 1, 0, 1);
    add_step("rd_byte3_sext", 0, 3, 12, SIZE_BYTE, 1, 0, 0, 3, 0, 1);
    add_step("rd_half1_zext", 0, 3, 12, SIZE_HALF, 0, 0, 0, 2, 0, 1);
    add_step("rd_half1_sext", 0, 3, 12, SIZE_HALF, 1, 0, 0, 2, 0, 1);
    add_step("wr_mask_base", 1, 0, 20, SIZE_WORD, 0, 0, 0, 0, 32'h0, 0);
    add_step("wr_mask_1010", 1, 0, 20, SIZE_BYTE, 0, 1, 4'b1010, 1, 32'hCAFE_BABE, 0);
    add_step("rd_mask_1010", 0, 0, 20, SIZE_WORD, 0, 0, 0, 0, 0, 1);
    add_step("wr_mask_0001", 1, 0, 20, SIZE_HALF, 0, 1, 4'b0001, 2, 32'h1234_5678, 0);
    add_step("rd_mask_0001", 0, 0, 20, SIZE_WORD, 0, 0, 0, 0, 0, 1);
    // Writes with the check flag confirm data_o still holds the older load
    add_step("wr_hold_base", 1, 1, 30, SIZE_WORD, 0, 0, 0, 0, 32'h0BAD_F00D, 0);
    add_step("rd_hold_byte", 0, 1, 30, SIZE_BYTE, 1, 0, 0, 2, 0, 1);
    add_step("wr_hold_word", 1, 1, 30, SIZE_WORD, 0, 0, 0, 0, 32'h1234_5678, 1);
    add_step("wr_hold_half", 1, 1, 30, SIZE_HALF, 0, 0, 0, 0, 32'h0000_0000, 1);
    add_step("rd_hold_new", 0, 1, 30, SIZE_WORD, 0, 0, 0, 0, 0, 1);
  endtask

  task automatic drive_step(input int i);
    v        = 1'b1;
    wr       = tbl_write[i];
    way_id   = tbl_way[i];
    addr     = tbl_addr[i];
    size_op  = tbl_size[i];
    sigext   = tbl_sext[i];
    mask_op  = tbl_mop[i];
    mask     = tbl_mask[i];
    byte_sel = tbl_sel[i];
    wdata    = tbl_data[i];
    chk.note_test(tbl_name[i], tbl_check[i]);
  endtask

  task automatic drive_idle();
    v        = 1'b0;
    wr       = 1'b0;
    way_id   = '0;
    addr     = '0;
    size_op  = SIZE_BYTE;
    sigext   = 1'b0;
    mask_op  = 1'b0;
    mask     = '0;
    byte_sel = '0;
    wdata    = '0;
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    drive_idle();
    build_table();
    timeout_limit = 2 * n_steps + reset_cycles_lp + 20;
    repeat (reset_cycles_lp) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < n_steps; i++) begin
      drive_step(i);
      @(posedge clk);
      #1;
      drive_idle();
      @(posedge clk);
      #1;
    end
    @(negedge clk);
    #1;  // After the last hold compare on this edge
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
